/* sources.f */
common/render_pkg.sv
hdl/render_config.sv
render_manager/frame_clear.sv
depthbuffer/depth_buffer.sv
framebuffer/double_framebuffer.sv
hdl/render_top.sv
tests/render_assertions.sv
tests/render_tb.sv

/* Bender.yml */
package:
  name: render_backend

sources:
  - common/render_pkg.sv
  - hdl/render_config.sv
  - render_manager/frame_clear.sv
  - depthbuffer/depth_buffer.sv
  - framebuffer/double_framebuffer.sv
  - hdl/render_top.sv
  - target: test
    files:
      - tests/render_assertions.sv
      - tests/render_tb.sv

/* tests/render_tb.sv */
`default_nettype none

module render_tb
    import render_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 2000;

    logic               clk_render;
    logic               rst_render;
    logic               begin_frame;
    logic               cfg_write;
    cfg_op_t            cfg_op;
    logic [11:0]        cfg_data;
    logic               pix_in_valid;
    pixel_t             pix_in;
    logic               busy;
    logic [COORD_W-1:0] read_x;
    logic [COORD_W-1:0] read_y;
    color12_t           read_data;

    // Reference model of both banks and of depth
    color12_t ref_bank [2][FB_PIXELS];
    depth_t   ref_depth [FB_PIXELS];
    logic     ref_front;
    color12_t ref_clear;
    logic     ref_depth_en;

    int       checks;
    int       errors;
    int       mark;
    integer   seed;

    render_top dut0 (.*);

    bind render_top render_assertions asrt0 (
        .clk_render   (clk_render),
        .rst_render   (rst_render),
        .begin_frame  (begin_frame),
        .pix_in_valid (pix_in_valid),
        .busy         (busy),
        .fb_we        (fb_we),
        .clr_state    (clear0.state)
    );

    initial begin
        clk_render = 1'b0;
        forever #5 clk_render = ~clk_render;
    end

    // ------------------------------
    // Model updates
    // ------------------------------
    function automatic void model_frame();
        int a;
        ref_front = !ref_front;
        for (a = 0; a < FB_PIXELS; a++) begin
            ref_bank[!ref_front][a] = ref_clear;
            ref_depth[a] = DEPTH_FAR;
        end
    endfunction

    function automatic void model_pixel(input pixel_t p);
        int a;
        a = p.y[FB_Y_W-1:0] * FB_WIDTH + p.x[FB_X_W-1:0];
        if (!p.compare_depth || !ref_depth_en || p.depth < ref_depth[a]) begin
            ref_depth[a] = p.depth;
            ref_bank[!ref_front][a] = p.color;
        end
    endfunction

    // ------------------------------
    // Bus drivers
    // ------------------------------
    task automatic write_config(input cfg_op_t op, input logic [11:0] data);
        @(posedge clk_render);
        cfg_write <= 1'b1;
        cfg_op    <= op;
        cfg_data  <= data;
        if (op == CFG_CLEAR_COLOR) begin
            ref_clear = color12_t'(data);
        end else if (op == CFG_DEPTH_ENABLE) begin
            ref_depth_en = data[0];
        end
        @(posedge clk_render);
        cfg_write <= 1'b0;
    endtask

    task automatic send_pixel(input int x, input int y, input depth_t d,
                              input color12_t c, input logic cmp);
        pixel_t p;
        p.x             = COORD_W'(x);
        p.y             = COORD_W'(y);
        p.depth         = d;
        p.color         = c;
        p.compare_depth = cmp;
        @(posedge clk_render);
        pix_in_valid <= 1'b1;
        pix_in       <= p;
        model_pixel(p);
    endtask

    // Let the last pixel reach the back bank before any swap
    task automatic flush_pixels();
        @(posedge clk_render);
        pix_in_valid <= 1'b0;
        repeat (DEPTH_LATENCY + 1) @(posedge clk_render);
    endtask

    task automatic start_frame();
        int n;
        n = 0;
        @(posedge clk_render);
        begin_frame <= 1'b1;
        @(posedge clk_render);
        begin_frame <= 1'b0;
        model_frame();
        @(posedge clk_render);
        while (busy !== 1'b0 && n < TIMEOUT) begin
            @(posedge clk_render);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("Timeout: busy still high %0d cycles after frame start", n);
            $display("Checks failed");
            $finish;
        end else begin
            // One sweep cycle per address plus the drain
            checks++;
            assert (n == FB_PIXELS + DEPTH_LATENCY) else begin
                $display("Error %0t: busy high for %0d cycles, expected %0d",
                         $time, n, FB_PIXELS + DEPTH_LATENCY);
                errors++;
            end
        end
    endtask

    // Pipelined readback, data trails the address by two edges
    task automatic check_front();
        int a;
        color12_t expected;
        for (a = 0; a < FB_PIXELS + 2; a++) begin
            @(posedge clk_render);
            if (a >= 2) begin
                expected = ref_bank[ref_front][a-2];
                checks++;
                assert (read_data === expected) else begin
                    $display("Error %0t: address %0d expected %h got %h",
                             $time, a - 2, expected, read_data);
                    errors++;
                end
            end
            if (a < FB_PIXELS) begin
                read_x <= COORD_W'(a % FB_WIDTH);
                read_y <= COORD_W'(a / FB_WIDTH);
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - mark);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic clear_color_fill();
        mark = errors;
        write_config(CFG_CLEAR_COLOR, 12'h35A);
        start_frame();
        start_frame();
        check_front();
        finish_test("clear");
    endtask

    task automatic nearer_depth_wins();
        mark = errors;
        start_frame();
        send_pixel(3, 2, 16'h0100, 12'hF00, 1'b1);
        send_pixel(3, 2, 16'h0200, 12'h0F0, 1'b1);
        send_pixel(7, 9, 16'h0200, 12'h0F0, 1'b1);
        send_pixel(7, 9, 16'h0100, 12'hF00, 1'b1);
        // Far pixel over a cleared entry must not write
        send_pixel(20, 5, DEPTH_FAR, 12'h00F, 1'b1);
        flush_pixels();
        start_frame();
        check_front();
        finish_test("depth_order");
    endtask

    task automatic compare_off_override();
        mark = errors;
        start_frame();
        send_pixel(10, 4, 16'h0010, 12'hABC, 1'b1);
        send_pixel(10, 4, 16'h0500, 12'h123, 1'b0);
        send_pixel(10, 4, 16'h0300, 12'h456, 1'b1);
        send_pixel(11, 4, 16'h0020, 12'h789, 1'b1);
        send_pixel(11, 4, 16'h4000, 12'h0AA, 1'b0);
        flush_pixels();
        start_frame();
        check_front();
        finish_test("override");
    endtask

    task automatic depth_off_last_wins();
        mark = errors;
        write_config(CFG_DEPTH_ENABLE, 12'h000);
        start_frame();
        send_pixel(5, 5, 16'h0010, 12'h111, 1'b1);
        send_pixel(5, 5, 16'h0800, 12'h222, 1'b1);
        send_pixel(5, 5, 16'h0900, 12'h333, 1'b1);
        send_pixel(6, 1, 16'h0050, 12'h444, 1'b1);
        send_pixel(6, 1, DEPTH_FAR, 12'h555, 1'b1);
        flush_pixels();
        write_config(CFG_DEPTH_ENABLE, 12'h001);
        start_frame();
        check_front();
        finish_test("depth_disable");
    endtask

    // Back bank was cleared by the previous frame start
    task automatic front_bank_holds();
        mark = errors;
        send_pixel(0, 0, 16'h0001, 12'hE01, 1'b1);
        send_pixel(31, 15, 16'h0002, 12'hE02, 1'b1);
        send_pixel(5, 5, 16'h0003, 12'hE03, 1'b1);
        send_pixel(16, 8, 16'h0004, 12'hE04, 1'b1);
        flush_pixels();
        check_front();
        start_frame();
        check_front();
        finish_test("double_buffer");
    endtask

    task automatic random_stream();
        int i;
        logic [31:0] r1;
        logic [31:0] r2;
        mark = errors;
        write_config(CFG_CLEAR_COLOR, 12'h0C3);
        start_frame();
        for (i = 0; i < 200; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            send_pixel(int'(r1[4:0]), int'(r1[8:5]), r2[15:0], r2[27:16],
                       r1[11:9] != 3'd0);
        end
        flush_pixels();
        start_frame();
        check_front();
        finish_test("random");
    endtask

    initial begin
        seed         = 80365;
        checks       = 0;
        errors       = 0;
        mark         = 0;
        ref_front    = 1'b0;
        ref_clear    = '0;
        ref_depth_en = 1'b1;
        rst_render   = 1'b1;
        begin_frame  = 1'b0;
        cfg_write    = 1'b0;
        cfg_op       = CFG_NOP;
        cfg_data     = '0;
        pix_in_valid = 1'b0;
        pix_in       = '0;
        read_x       = '0;
        read_y       = '0;
        repeat (5) @(posedge clk_render);
        rst_render <= 1'b0;

        clear_color_fill();
        nearer_depth_wins();
        compare_off_override();
        depth_off_last_wins();
        front_bank_holds();
        random_stream();

        errors = errors + dut0.asrt0.fail_count;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/render_assertions.sv */
`default_nettype none

module render_assertions
    import render_pkg::*;
(
    input wire logic         clk_render,
    input wire logic         rst_render,
    input wire logic         begin_frame,
    input wire logic         pix_in_valid,
    input wire logic         busy,
    input wire logic         fb_we,
    input wire clear_state_t clr_state
);

    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Upstream holds off while a clear runs
    no_input_while_busy: assert property (
        @(posedge clk_render) disable iff (rst_render) busy |-> !pix_in_valid
    ) else begin
        $error("pixel input offered while busy");
        fail_count++;
    end

    busy_after_begin: assert property (
        @(posedge clk_render) disable iff (rst_render) begin_frame |=> busy
    ) else begin
        $error("busy not high one cycle after begin_frame");
        fail_count++;
    end

    fb_we_in_reset: assert property (
        @(posedge clk_render) rst_render |-> !fb_we
    ) else begin
        $error("framebuffer write strobe high during reset");
        fail_count++;
    end

    // The clear always ends through the drain cycles
    busy_falls_from_drain: assert property (
        @(posedge clk_render) disable iff (rst_render)
            $fell(busy) |-> $past(clr_state) == CLR_DRAIN
    ) else begin
        $error("busy fell outside the drain state");
        fail_count++;
    end

endmodule

`default_nettype wire

/* hdl/render_top.sv */
`default_nettype none

module render_top
    import render_pkg::*;
(
    input  wire logic               clk_render,
    input  wire logic               rst_render,

    input  wire logic               begin_frame,

    // Configuration strobe
    input  wire logic               cfg_write,
    input  wire cfg_op_t            cfg_op,
    input  wire logic [11:0]        cfg_data,

    // Shaded pixels, held off while busy
    input  wire logic               pix_in_valid,
    input  wire pixel_t             pix_in,
    output logic                    busy,

    // Front bank readback
    input  wire logic [COORD_W-1:0] read_x,
    input  wire logic [COORD_W-1:0] read_y,
    output color12_t                read_data
);

    color12_t  clear_color;
    logic      depth_enable;
    logic      pix_valid;
    pixel_t    pix;
    logic      fb_we;
    fb_write_t fb_wr;

    // ------------------------------
    // Configuration
    // ------------------------------
    render_config config0 (
        .clk_render   (clk_render),
        .rst_render   (rst_render),
        .cfg_write    (cfg_write),
        .cfg_op       (cfg_op),
        .cfg_data     (cfg_data),
        .clear_color  (clear_color),
        .depth_enable (depth_enable)
    );

    // ------------------------------
    // Clear, depth, framebuffer
    // ------------------------------
    frame_clear clear0 (
        .clk_render   (clk_render),
        .rst_render   (rst_render),
        .begin_frame  (begin_frame),
        .clear_color  (clear_color),
        .pix_in_valid (pix_in_valid),
        .pix_in       (pix_in),
        .pix_valid    (pix_valid),
        .pix          (pix),
        .busy         (busy)
    );

    depth_buffer depth0 (
        .clk_render   (clk_render),
        .rst_render   (rst_render),
        .depth_enable (depth_enable),
        .pix_valid    (pix_valid),
        .pix          (pix),
        .fb_we        (fb_we),
        .fb_wr        (fb_wr)
    );

    // Frame start doubles as the bank swap
    double_framebuffer fb0 (
        .clk_render (clk_render),
        .rst_render (rst_render),
        .swap       (begin_frame),
        .fb_we      (fb_we),
        .fb_wr      (fb_wr),
        .read_x     (read_x),
        .read_y     (read_y),
        .read_data  (read_data)
    );

endmodule

`default_nettype wire

/* framebuffer/double_framebuffer.sv */
`default_nettype none

module double_framebuffer
    import render_pkg::*;
(
    input  wire logic               clk_render,
    input  wire logic               rst_render,

    input  wire logic               swap,

    // Write side, always the back bank
    input  wire logic               fb_we,
    input  wire fb_write_t          fb_wr,

    // Read side, always the front bank
    input  wire logic [COORD_W-1:0] read_x,
    input  wire logic [COORD_W-1:0] read_y,
    output color12_t                read_data
);

    color12_t bank0 [FB_PIXELS];
    color12_t bank1 [FB_PIXELS];

    // Index of the bank currently on display
    logic                 front_sel;
    logic [FB_ADDR_W-1:0] wr_addr;
    logic [FB_ADDR_W-1:0] rd_addr;

    assign wr_addr = {fb_wr.y[FB_Y_W-1:0], fb_wr.x[FB_X_W-1:0]};
    assign rd_addr = {read_y[FB_Y_W-1:0], read_x[FB_X_W-1:0]};

    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            front_sel <= 1'b0;
        end else if (swap) begin
            front_sel <= ~front_sel;
        end
    end

    // ------------------------------
    // Bank storage
    // ------------------------------
    always_ff @(posedge clk_render) begin
        if (fb_we) begin
            if (front_sel) begin
                bank0[wr_addr] <= fb_wr.color;
            end else begin
                bank1[wr_addr] <= fb_wr.color;
            end
        end
    end

    always_ff @(posedge clk_render) begin
        read_data <= front_sel ? bank1[rd_addr] : bank0[rd_addr];
    end

endmodule

`default_nettype wire

/* depthbuffer/depth_buffer.sv */
`default_nettype none

module depth_buffer
    import render_pkg::*;
(
    input  wire logic   clk_render,
    input  wire logic   rst_render,

    input  wire logic   depth_enable,

    input  wire logic   pix_valid,
    input  wire pixel_t pix,

    // Framebuffer write port
    output logic        fb_we,
    output fb_write_t   fb_wr
);

    depth_t depth_mem [FB_PIXELS];

    // ------------------------------
    // Stage one: address and read
    // ------------------------------
    logic [FB_ADDR_W-1:0] s1_addr;

    // Stage two registers
    logic                 st2_valid;
    pixel_t               st2_pix;
    logic [FB_ADDR_W-1:0] st2_addr;
    depth_t               st2_mem_depth;
    logic                 st2_fwd_hit;
    depth_t               st2_fwd_depth;

    // Stage two decision
    depth_t               st2_stored;
    logic                 st2_pass;
    logic                 st2_write;

    assign s1_addr = {pix.y[FB_Y_W-1:0], pix.x[FB_X_W-1:0]};

    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            st2_valid <= 1'b0;
        end else begin
            st2_valid <= pix_valid;
        end
    end

    // The memory read misses a write landing on the same edge,
    // so the pending stage two result is captured alongside
    always_ff @(posedge clk_render) begin
        st2_pix       <= pix;
        st2_addr      <= s1_addr;
        st2_mem_depth <= depth_mem[s1_addr];
        st2_fwd_hit   <= st2_write && (st2_addr == s1_addr);
        st2_fwd_depth <= st2_pix.depth;
    end

    // ------------------------------
    // Stage two: compare and write
    // ------------------------------
    assign st2_stored = st2_fwd_hit ? st2_fwd_depth : st2_mem_depth;

    always_comb begin
        if (!st2_pix.compare_depth || !depth_enable) begin
            st2_pass = 1'b1;
        end else begin
            st2_pass = (st2_pix.depth < st2_stored);
        end
    end

    assign st2_write = st2_valid && st2_pass;

    always_ff @(posedge clk_render) begin
        if (st2_write) begin
            depth_mem[st2_addr] <= st2_pix.depth;
        end
    end

    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            fb_we <= 1'b0;
        end else begin
            fb_we <= st2_write;
        end
    end

    always_ff @(posedge clk_render) begin
        fb_wr.x     <= st2_pix.x;
        fb_wr.y     <= st2_pix.y;
        fb_wr.color <= st2_pix.color;
    end

endmodule

`default_nettype wire

/* render_manager/frame_clear.sv */
`default_nettype none

module frame_clear
    import render_pkg::*;
(
    input  wire logic     clk_render,
    input  wire logic     rst_render,

    input  wire logic     begin_frame,
    input  wire color12_t clear_color,

    // Shaded pixel stream from upstream
    input  wire logic     pix_in_valid,
    input  wire pixel_t   pix_in,

    // Stream towards the depth test
    output logic          pix_valid,
    output pixel_t        pix,
    output logic          busy
);

    localparam logic [FB_ADDR_W-1:0] LAST_ADDR = FB_ADDR_W'(FB_PIXELS - 1);
    localparam logic [1:0]           LAST_DRAIN = 2'(DEPTH_LATENCY - 1);

    clear_state_t         state;
    logic [FB_ADDR_W-1:0] clr_addr;
    logic [1:0]           drain_cnt;
    pixel_t               clr_pix;

    assign busy = (state != CLR_IDLE);

    // Raster order, x in the low address bits
    always_comb begin
        clr_pix               = '0;
        clr_pix.x             = COORD_W'(clr_addr[FB_X_W-1:0]);
        clr_pix.y             = COORD_W'(clr_addr[FB_ADDR_W-1:FB_X_W]);
        clr_pix.depth         = DEPTH_FAR;
        clr_pix.color         = clear_color;
        clr_pix.compare_depth = 1'b0;
    end

    // ------------------------------
    // Clear sequencer
    // ------------------------------
    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            state     <= CLR_IDLE;
            clr_addr  <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                CLR_IDLE: begin
                    if (begin_frame) begin
                        state    <= CLR_SWEEP;
                        clr_addr <= '0;
                    end
                end
                CLR_SWEEP: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == LAST_ADDR) begin
                        state     <= CLR_DRAIN;
                        drain_cnt <= '0;
                    end
                end
                CLR_DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == LAST_DRAIN) begin
                        state <= CLR_IDLE;
                    end
                end
                default: state <= CLR_IDLE;
            endcase
        end
    end

    // Input is only taken while idle and not starting a frame
    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= (state == CLR_SWEEP) ||
                         ((state == CLR_IDLE) && pix_in_valid && !begin_frame);
        end
    end

    always_ff @(posedge clk_render) begin
        pix <= (state == CLR_SWEEP) ? clr_pix : pix_in;
    end

endmodule

`default_nettype wire

/* hdl/render_config.sv */
`default_nettype none

module render_config
    import render_pkg::*;
(
    input  wire logic    clk_render,
    input  wire logic    rst_render,

    // Software write strobe
    input  wire logic    cfg_write,
    input  wire cfg_op_t cfg_op,
    input  wire logic [11:0] cfg_data,

    output color12_t     clear_color,
    output logic         depth_enable
);

    // Depth test is on out of reset, clear colour is black
    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            clear_color  <= '0;
            depth_enable <= 1'b1;
        end else if (cfg_write) begin
            case (cfg_op)
                CFG_CLEAR_COLOR: begin
                    clear_color <= color12_t'(cfg_data);
                end
                CFG_DEPTH_ENABLE: begin
                    depth_enable <= cfg_data[0];
                end
                default: begin
                    // NOP and unused codes leave both registers alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/render_pkg.sv */
`default_nettype none

package render_pkg;

    // ------------------------------
    // Framebuffer geometry
    // ------------------------------
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 16;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDR_W = $clog2(FB_PIXELS);
    localparam int FB_X_W    = $clog2(FB_WIDTH);
    localparam int FB_Y_W    = FB_ADDR_W - FB_X_W;
    localparam int COORD_W   = 8;

    // Pixel entry to framebuffer write strobe
    localparam int DEPTH_LATENCY = 2;

    // ------------------------------
    // Pixel types
    // ------------------------------
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } color12_t;

    // Smaller is nearer
    typedef logic [15:0] depth_t;

    localparam depth_t DEPTH_FAR = 16'hFFFF;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        depth_t             depth;
        color12_t           color;
        logic               compare_depth;
    } pixel_t;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        color12_t           color;
    } fb_write_t;

    // ------------------------------
    // Control encodings
    // ------------------------------
    typedef enum logic [1:0] {
        CFG_NOP          = 2'd0,
        CFG_CLEAR_COLOR  = 2'd1,
        CFG_DEPTH_ENABLE = 2'd2
    } cfg_op_t;

    typedef enum logic [1:0] {
        CLR_IDLE  = 2'd0,
        CLR_SWEEP = 2'd1,
        CLR_DRAIN = 2'd2
    } clear_state_t;

endpackage

`default_nettype wire
